// File: verification/queue_mem_cases.txt
# load queue page offset | enq data keep last queue cur_page next_page tail_offset
# deq queue data keep last port bytes free_page (none when no page is freed), all hex
load 0 1 0
load 2 5 2
load 5 3 3
load 7 c 1
enq deadbeef f 1 0 1 2 0
enq 20000001 f 0 2 5 9 2
enq 20000002 f 0 0 0 0 0
enq 20000003 f 0 0 0 0 0
enq 20000004 f 0 0 0 0 0
enq 20000005 7 1 0 0 0 0
enq 5a5a0001 1 1 5 3 4 3
enq 70000001 f 0 7 c d 1
enq 70000002 3 1 0 0 0 0
deq 2 20000001 f 0 1 4 none
deq 0 deadbeef f 1 0 4 none
deq 2 20000002 f 0 1 4 5
deq 5 5a5a0001 1 1 2 1 3
deq 2 20000003 f 0 1 4 none
deq 7 70000001 f 0 3 4 none
deq 2 20000004 f 0 1 4 none
deq 7 70000002 3 1 3 2 none
deq 2 20000005 7 1 1 3 none

// File: tb.f
design/queue_cfg_pkg.sv
design/queue_msg_pkg.sv
design/queue_ifs.sv
design/enqueue_writer.sv
design/page_store.sv
design/head_pointer_table.sv
design/dequeue_reader.sv
design/queue_mem_top.sv
verification/queue_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the queue memory testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module queue_mem_tb -Mdir "$build_dir" -o queue_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/queue_mem_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q -F "*** TEST FAILED ***" "$log_file"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: verification/queue_mem_tb.sv
/* Queue memory testbench
   Replays the cases file through the DUT and checks every dequeued word */

`timescale 1ns/1ps

module queue_mem_tb
    import queue_cfg_pkg::*;
    import queue_msg_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int REQ_TIMEOUT   = 20;
    localparam int DRAIN_TIMEOUT = 40;
    localparam int SEED          = 11;

    typedef enum logic [1:0] {
        op_load,
        op_enq,
        op_deq
    } case_op_t;

    // One dequeued word as the cases file describes it
    typedef struct packed {
        logic [DATA_W-1:0]     data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        logic [PORT_W-1:0]     port;
        logic [BYTE_CNT_W-1:0] nbytes;
        logic [QUEUE_W-1:0]    queue;
        logic                  free_en;
        logic [PAGE_W-1:0]     free_page;
        logic [31:0]           req_cycle;
    } expect_t;

    logic                  packet_in;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    logic [DATA_W-1:0]     in_data;
    logic [DATA_BYTES-1:0] in_keep;
    logic                  in_last;
    enq_meta_t             in_meta;
    logic                  load_valid;
    logic [QUEUE_W-1:0]    load_queue;
    head_ptr_t             load_head;
    logic                  req_valid;
    logic                  req_ready;
    logic [QUEUE_W-1:0]    req_queue;
    logic                  out_valid;
    logic [DATA_W-1:0]     out_data;
    logic [DATA_BYTES-1:0] out_keep;
    logic                  out_last;
    logic [PORT_W-1:0]     out_port;
    logic                  notify_valid;
    logic [BYTE_CNT_W-1:0] notify_bytes;
    logic [QUEUE_W-1:0]    notify_queue;
    logic                  notify_last;
    logic                  free_valid;
    logic [PAGE_W-1:0]     free_page;

    expect_t     expected_q [$];
    logic [31:0] cycle_cnt = '0;

    queue_mem_top queue_mem_top_i (
        .packet_in, .reset,
        .in_valid, .in_ready, .in_data, .in_keep, .in_last, .in_meta,
        .load_valid, .load_queue, .load_head,
        .req_valid, .req_ready, .req_queue,
        .out_valid, .out_data, .out_keep, .out_last, .out_port,
        .notify_valid, .notify_bytes, .notify_queue, .notify_last,
        .free_valid, .free_page
    );

    initial begin
        packet_in = 1'b0;
        forever #(CLK_PERIOD / 2) packet_in = ~packet_in;
    end

    always @(posedge packet_in) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("** Error: %s expected 0x%0h actual 0x%0h",
                                          name, expected, actual));
    endtask

    // Sampled at the falling edge between register updates
    task automatic check_outputs();
        expect_t e;
        if (out_valid === 1'b1) begin
            assert (expected_q.size() != 0)
                else report_failure("out_valid asserted with no dequeue request outstanding");
            e = expected_q.pop_front();
            assert (cycle_cnt == e.req_cycle + 32'd4)
                else report_failure(
                    $sformatf("word for queue %0d came %0d cycles after its request",
                              e.queue, cycle_cnt - e.req_cycle));
            check_value("out_data", e.data, out_data);
            check_value("out_keep", 32'(e.keep), 32'(out_keep));
            check_value("out_last", 32'(e.last), 32'(out_last));
            check_value("out_port", 32'(e.port), 32'(out_port));
            check_value("notify_valid", 32'd1, 32'(notify_valid));
            check_value("notify_bytes", 32'(e.nbytes), 32'(notify_bytes));
            check_value("notify_queue", 32'(e.queue), 32'(notify_queue));
            check_value("notify_last", 32'(e.last), 32'(notify_last));
            check_value("free_valid", 32'(e.free_en), 32'(free_valid));
            if (e.free_en) begin
                check_value("free_page", 32'(e.free_page), 32'(free_page));
            end
        end else begin
            assert (out_valid === 1'b0)
                else report_failure("out_valid is unknown");
            assert (notify_valid === 1'b0)
                else report_failure("notify_valid high without an output word");
            assert (free_valid === 1'b0)
                else report_failure("free_valid pulsed without an output word");
        end
    endtask

    always @(negedge packet_in) begin
        check_outputs();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks start and end on a falling edge

    task automatic apply_load(input logic [QUEUE_W-1:0] queue, input head_ptr_t head);
        load_valid = 1'b1;
        load_queue = queue;
        load_head  = head;
        @(negedge packet_in);
        load_valid = 1'b0;
    endtask

    task automatic send_word(input logic [DATA_W-1:0] data, input logic [DATA_BYTES-1:0] keep,
                             input logic last, input enq_meta_t meta);
        assert (in_ready === 1'b1)
            else report_failure("in_ready low while a packet word was offered");
        in_valid = 1'b1;
        in_data  = data;
        in_keep  = keep;
        in_last  = last;
        in_meta  = meta;
        @(negedge packet_in);
        in_valid = 1'b0;
    endtask

    task automatic request_word(input logic [QUEUE_W-1:0] queue, input expect_t exp_word);
        int      waited;
        expect_t e;
        waited    = 0;
        // Request stays offered while the requester is still busy
        req_valid = 1'b1;
        req_queue = queue;
        while (req_ready !== 1'b1) begin
            assert (waited < REQ_TIMEOUT)
                else report_failure("timed out waiting for req_ready");
            @(negedge packet_in);
            waited++;
        end
        e           = exp_word;
        e.queue     = queue;
        e.req_cycle = cycle_cnt;
        expected_q.push_back(e);
        @(negedge packet_in);
        req_valid = 1'b0;
        // Requester is busy with the APB transfer now
        assert (req_ready === 1'b0)
            else report_failure("req_ready stayed high right after a request was accepted");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        string       line;
        string       op_str;
        string       free_str;
        int          fd;
        int          n;
        int          waited;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6;
        case_op_t    op;
        case_op_t    prev_op;
        bit          first_op;
        head_ptr_t   head;
        enq_meta_t   meta;
        expect_t     exp_word;

        reset      = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        in_keep    = '0;
        in_last    = 1'b0;
        in_meta    = '0;
        load_valid = 1'b0;
        load_queue = '0;
        load_head  = '0;
        req_valid  = 1'b0;
        req_queue  = '0;
        void'($urandom(SEED));

        fd = $fopen("verification/queue_mem_cases.txt", "r");
        assert (fd != 0)
            else report_failure("could not open verification/queue_mem_cases.txt");

        repeat (2) @(negedge packet_in);
        reset = 1'b0;

        first_op = 1'b1;
        prev_op  = op_load;
        op       = op_load;
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines
            if (line.getc(0) == "#" || $sscanf(line, "%s", op_str) != 1) begin
                continue;
            end
            if (op_str == "load") begin
                op = op_load;
            end else if (op_str == "enq") begin
                op = op_enq;
            end else if (op_str == "deq") begin
                op = op_deq;
            end else begin
                report_failure($sformatf("unknown opcode %s in cases file", op_str));
            end

            // Random idle gap when the kind of operation changes
            if (!first_op && op != prev_op) begin
                repeat (1 + int'($urandom % 3)) @(negedge packet_in);
            end
            first_op = 1'b0;
            prev_op  = op;

            if (op == op_load) begin
                n = $sscanf(line, "%s %h %h %h", op_str, f0, f1, f2);
                assert (n == 4) else report_failure("malformed load line in cases file");
                head.page   = PAGE_W'(f1);
                head.offset = OFFSET_W'(f2);
                apply_load(QUEUE_W'(f0), head);
            end else if (op == op_enq) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h", op_str, f0, f1, f2, f3, f4, f5, f6);
                assert (n == 8) else report_failure("malformed enq line in cases file");
                meta.queue_id    = QUEUE_W'(f3);
                meta.cur_page    = PAGE_W'(f4);
                meta.next_page   = PAGE_W'(f5);
                meta.tail_offset = OFFSET_W'(f6);
                send_word(f0, DATA_BYTES'(f1), f2[0], meta);
            end else begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %s",
                            op_str, f0, f1, f2, f3, f4, f5, free_str);
                assert (n == 8) else report_failure("malformed deq line in cases file");
                exp_word         = '0;
                exp_word.data    = f1;
                exp_word.keep    = DATA_BYTES'(f2);
                exp_word.last    = f3[0];
                exp_word.port    = PORT_W'(f4);
                exp_word.nbytes  = BYTE_CNT_W'(f5);
                exp_word.free_en = (free_str != "none");
                if (exp_word.free_en) begin
                    n = $sscanf(free_str, "%h", f6);
                    assert (n == 1) else report_failure("malformed free page in cases file");
                    exp_word.free_page = PAGE_W'(f6);
                end
                request_word(QUEUE_W'(f0), exp_word);
            end
        end
        $fclose(fd);

        waited = 0;
        while (expected_q.size() != 0) begin
            assert (waited < DRAIN_TIMEOUT)
                else report_failure("timed out waiting for the remaining dequeued words");
            @(negedge packet_in);
            waited++;
        end
        // Quiet period to catch stray outputs
        repeat (4) @(negedge packet_in);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: design/queue_mem_top.sv
/* Packet queue memory
   Paged egress queue storage with head pointer table and dequeue pipeline */

`timescale 1ns/1ps

module queue_mem_top
    import queue_cfg_pkg::*;
    import queue_msg_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  reset,
    // Packet input
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [DATA_W-1:0]     in_data,
    input  logic [DATA_BYTES-1:0] in_keep,
    input  logic                  in_last,
    input  enq_meta_t             in_meta,
    // Head load
    input  logic                  load_valid,
    input  logic [QUEUE_W-1:0]    load_queue,
    input  head_ptr_t             load_head,
    // Dequeue request
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [QUEUE_W-1:0]    req_queue,
    // Word output
    output logic                  out_valid,
    output logic [DATA_W-1:0]     out_data,
    output logic [DATA_BYTES-1:0] out_keep,
    output logic                  out_last,
    output logic [PORT_W-1:0]     out_port,
    // Dequeue notification
    output logic                  notify_valid,
    output logic [BYTE_CNT_W-1:0] notify_bytes,
    output logic [QUEUE_W-1:0]    notify_queue,
    output logic                  notify_last,
    // Page free
    output logic                  free_valid,
    output logic [PAGE_W-1:0]     free_page
);

    apb_if    apb_bus ();
    mem_wr_if mem_bus ();

    logic                  link_valid;
    logic [PAGE_W-1:0]     link_page;
    logic [PAGE_W-1:0]     link_next;
    logic                  rd_en;
    logic [ADDR_W-1:0]     rd_addr;
    logic [DATA_W-1:0]     rd_data;
    logic [KEEP_ENC_W-1:0] rd_keep_enc;
    logic                  rd_last;

    enqueue_writer enqueue_writer_i (
        .packet_in, .reset,
        .in_valid, .in_ready, .in_data, .in_keep, .in_last, .in_meta,
        .mem (mem_bus.writer),
        .link_valid, .link_page, .link_next
    );

    page_store page_store_i (
        .packet_in, .reset,
        .mem (mem_bus.store),
        .rd_en, .rd_addr, .rd_data, .rd_keep_enc, .rd_last
    );

    head_pointer_table head_pointer_table_i (
        .packet_in, .reset,
        .apb (apb_bus.completer),
        .load_valid, .load_queue, .load_head,
        .link_valid, .link_page, .link_next
    );

    dequeue_reader dequeue_reader_i (
        .packet_in, .reset,
        .req_valid, .req_ready, .req_queue,
        .apb (apb_bus.requester),
        .rd_en, .rd_addr, .rd_data, .rd_keep_enc, .rd_last,
        .out_valid, .out_data, .out_keep, .out_last, .out_port,
        .notify_valid, .notify_bytes, .notify_queue, .notify_last,
        .free_valid, .free_page
    );

endmodule

// File: design/dequeue_reader.sv
/* Dequeue reader
   APB head pointer requester and the read pipeline to word, notify and free outputs */

`timescale 1ns/1ps

module dequeue_reader
    import queue_cfg_pkg::*;
    import queue_msg_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [QUEUE_W-1:0]    req_queue,
    apb_if.requester              apb,
    output logic                  rd_en,
    output logic [ADDR_W-1:0]     rd_addr,
    input  logic [DATA_W-1:0]     rd_data,
    input  logic [KEEP_ENC_W-1:0] rd_keep_enc,
    input  logic                  rd_last,
    output logic                  out_valid,
    output logic [DATA_W-1:0]     out_data,
    output logic [DATA_BYTES-1:0] out_keep,
    output logic                  out_last,
    output logic [PORT_W-1:0]     out_port,
    output logic                  notify_valid,
    output logic [BYTE_CNT_W-1:0] notify_bytes,
    output logic [QUEUE_W-1:0]    notify_queue,
    output logic                  notify_last,
    output logic                  free_valid,
    output logic [PAGE_W-1:0]     free_page
);

    apb_state_t         state;
    logic [QUEUE_W-1:0] qid_apb;
    logic [QUEUE_W-1:0] qid_rd;
    logic [QUEUE_W-1:0] qid_out;
    head_ptr_t          head_q;
    logic               rd_pending;
    logic               out_stage;
    logic               apb_done;

    ////////////////////////////////////////////////////////////////////////////
    // APB requester, one transfer per request
    assign req_ready   = (state == apb_idle);
    assign apb.psel    = (state != apb_idle);
    assign apb.penable = (state == apb_access);
    assign apb.paddr   = qid_apb;
    assign apb_done    = apb.psel & apb.penable & apb.pready;

    always_ff @(posedge packet_in) begin
        if (reset) begin
            state <= apb_idle;
        end else begin
            case (state)
                apb_idle:   if (req_valid) state <= apb_setup;
                apb_setup:  state <= apb_access;
                apb_access: if (apb.pready) state <= apb_idle;
                default:    state <= apb_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read pipeline, memory read then output
    assign rd_en   = rd_pending;
    assign rd_addr = head_q;

    always_ff @(posedge packet_in) begin
        if (reset) begin
            rd_pending <= 1'b0;
            out_stage  <= 1'b0;
            free_valid <= 1'b0;
        end else begin
            rd_pending <= apb_done;
            out_stage  <= rd_pending;
            // Last word of a page frees it
            free_valid <= rd_pending && (head_q.offset == OFFSET_W'(WORDS_PER_PAGE - 1));
        end
    end

    always_ff @(posedge packet_in) begin
        if (req_valid && req_ready) begin
            qid_apb <= req_queue;
        end
        if (apb_done) begin
            head_q <= apb.prdata;
            qid_rd <= qid_apb;
        end
        qid_out   <= qid_rd;
        free_page <= head_q.page;
    end

    // Word and notification come straight off the memory read register
    assign out_valid    = out_stage;
    assign out_data     = rd_data;
    assign out_keep     = decode_keep(rd_keep_enc);
    assign out_last     = rd_last;
    assign out_port     = PORT_W'(qid_out / QUEUES_PER_PORT);

    assign notify_valid = out_stage;
    assign notify_bytes = valid_bytes(rd_keep_enc);
    assign notify_queue = qid_out;
    assign notify_last  = rd_last;

endmodule

// File: design/head_pointer_table.sv
/* Head pointer table
   Per-queue head pointers read and advanced over APB, plus the page link memory */

`timescale 1ns/1ps

module head_pointer_table
    import queue_cfg_pkg::*;
    import queue_msg_pkg::*;
(
    input  logic               packet_in,
    input  logic               reset,
    apb_if.completer           apb,
    input  logic               load_valid,
    input  logic [QUEUE_W-1:0] load_queue,
    input  head_ptr_t          load_head,
    input  logic               link_valid,
    input  logic [PAGE_W-1:0]  link_page,
    input  logic [PAGE_W-1:0]  link_next
);

    head_ptr_t         heads    [NUM_QUEUES];
    logic [PAGE_W-1:0] link_mem [NUM_PAGES];
    head_ptr_t         cur_head;
    head_ptr_t         next_head;
    logic              apb_done;

    // Zero wait states
    assign apb.pready = apb.psel & apb.penable;
    assign apb_done   = apb.psel & apb.penable & apb.pready;

    assign cur_head   = heads[apb.paddr];
    assign apb.prdata = cur_head;

    // Step to the next word, or follow the link after the last word of a page
    always_comb begin
        next_head = cur_head;
        if (cur_head.offset == OFFSET_W'(WORDS_PER_PAGE - 1)) begin
            next_head.page   = link_mem[cur_head.page];
            next_head.offset = '0;
        end else begin
            next_head.offset = cur_head.offset + OFFSET_W'(1);
        end
    end

    always_ff @(posedge packet_in) begin
        if (reset) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                heads[q] <= '0;
            end
        end else begin
            if (apb_done) begin
                heads[apb.paddr] <= next_head;
            end
            // A load overrides an advance of the same queue
            if (load_valid) begin
                heads[load_queue] <= load_head;
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (link_valid) begin
            link_mem[link_page] <= link_next;
        end
    end

endmodule

// File: design/page_store.sv
/* Page store
   Data and byte-count memories, one write port and one registered read port */

`timescale 1ns/1ps

module page_store
    import queue_cfg_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  reset,
    mem_wr_if.store               mem,
    input  logic                  rd_en,
    input  logic [ADDR_W-1:0]     rd_addr,
    output logic [DATA_W-1:0]     rd_data,
    output logic [KEEP_ENC_W-1:0] rd_keep_enc,
    output logic                  rd_last
);

    logic [DATA_W-1:0]   data_mem [MEM_DEPTH];
    // Encoded byte count with the last flag on top
    logic [KEEP_ENC_W:0] blen_mem [MEM_DEPTH];

    always_ff @(posedge packet_in) begin
        if (mem.wr_en) begin
            data_mem[mem.wr_addr] <= mem.wr_data;
            blen_mem[mem.wr_addr] <= {mem.wr_last, mem.wr_keep_enc};
        end
        if (rd_en) begin
            rd_data <= data_mem[rd_addr];
        end
    end

    always_ff @(posedge packet_in) begin
        if (reset) begin
            rd_keep_enc <= '0;
            rd_last     <= 1'b0;
        end else if (rd_en) begin
            {rd_last, rd_keep_enc} <= blen_mem[rd_addr];
        end
    end

endmodule

// File: design/enqueue_writer.sv
/* Enqueue writer
   Places packet words into page memory and records page-to-page links */

`timescale 1ns/1ps

module enqueue_writer
    import queue_cfg_pkg::*;
    import queue_msg_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [DATA_W-1:0]     in_data,
    input  logic [DATA_BYTES-1:0] in_keep,
    input  logic                  in_last,
    input  enq_meta_t             in_meta,
    mem_wr_if.writer              mem,
    output logic                  link_valid,
    output logic [PAGE_W-1:0]     link_page,
    output logic [PAGE_W-1:0]     link_next
);

    logic                sop;
    logic [PAGE_W-1:0]   page_cnt;
    logic [OFFSET_W-1:0] offset_cnt;
    logic [PAGE_W-1:0]   next_page_q;
    logic [PAGE_W-1:0]   page_now;
    logic [OFFSET_W-1:0] offset_now;
    logic [PAGE_W-1:0]   next_now;
    logic                page_end;

    // No back-pressure on the packet input
    assign in_ready = 1'b1;

    // First word addresses from metadata, later words from the counters
    assign page_now   = sop ? in_meta.cur_page    : page_cnt;
    assign offset_now = sop ? in_meta.tail_offset : offset_cnt;
    assign next_now   = sop ? in_meta.next_page   : next_page_q;
    assign page_end   = (offset_now == OFFSET_W'(WORDS_PER_PAGE - 1));

    always_ff @(posedge packet_in) begin
        if (reset) begin
            sop        <= 1'b1;
            mem.wr_en  <= 1'b0;
            link_valid <= 1'b0;
        end else begin
            mem.wr_en  <= in_valid;
            link_valid <= in_valid && page_end;
            if (in_valid) begin
                sop         <= in_last;
                offset_cnt  <= offset_now + OFFSET_W'(1);
                page_cnt    <= page_end ? next_now : page_now;
                next_page_q <= next_now;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write stage payload
    always_ff @(posedge packet_in) begin
        mem.wr_addr     <= {page_now, offset_now};
        mem.wr_data     <= in_data;
        mem.wr_keep_enc <= encode_keep(in_keep);
        mem.wr_last     <= in_last;
        link_page       <= page_now;
        link_next       <= next_now;
    end

endmodule

// File: design/queue_ifs.sv
/* Internal links of the queue memory
   APB head pointer read and the page memory write port */

`timescale 1ns/1ps

// Head pointer read, paddr is the queue id
interface apb_if
    import queue_cfg_pkg::*;
    import queue_msg_pkg::*;
();
    logic               psel;
    logic               penable;
    logic [QUEUE_W-1:0] paddr;
    head_ptr_t          prdata;
    logic               pready;

    modport requester (
        output psel, penable, paddr,
        input  prdata, pready
    );

    modport completer (
        input  psel, penable, paddr,
        output prdata, pready
    );
endinterface

interface mem_wr_if
    import queue_cfg_pkg::*;
();
    logic                  wr_en;
    logic [ADDR_W-1:0]     wr_addr;
    logic [DATA_W-1:0]     wr_data;
    logic [KEEP_ENC_W-1:0] wr_keep_enc;
    logic                  wr_last;

    modport writer (output wr_en, wr_addr, wr_data, wr_keep_enc, wr_last);
    modport store  (input  wr_en, wr_addr, wr_data, wr_keep_enc, wr_last);
endinterface

// File: design/queue_msg_pkg.sv
/* Queue memory message types
   Head pointer and packet metadata structs, requester states, byte-enable coding */

package queue_msg_pkg;

    import queue_cfg_pkg::*;

    typedef struct packed {
        logic [PAGE_W-1:0]   page;
        logic [OFFSET_W-1:0] offset;
    } head_ptr_t;

    // Carried on the first word of every packet
    typedef struct packed {
        logic [QUEUE_W-1:0]  queue_id;
        logic [PAGE_W-1:0]   cur_page;
        logic [PAGE_W-1:0]   next_page;
        logic [OFFSET_W-1:0] tail_offset;
    } enq_meta_t;

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

    // Contiguous mask to byte count, full word maps to zero
    function automatic logic [KEEP_ENC_W-1:0] encode_keep(input logic [DATA_BYTES-1:0] keep);
        logic [KEEP_ENC_W-1:0] enc;
        enc = '0;
        for (int i = DATA_BYTES - 1; i >= 1; i--) begin
            if (!keep[i]) begin
                enc = KEEP_ENC_W'(i);
            end
        end
        return enc;
    endfunction

    function automatic logic [DATA_BYTES-1:0] decode_keep(input logic [KEEP_ENC_W-1:0] enc);
        logic [DATA_BYTES-1:0] keep;
        keep = '1;
        if (enc != '0) begin
            for (int i = 0; i < DATA_BYTES; i++) begin
                keep[i] = (i < int'(enc));
            end
        end
        return keep;
    endfunction

    function automatic logic [BYTE_CNT_W-1:0] valid_bytes(input logic [KEEP_ENC_W-1:0] enc);
        return (enc == '0) ? BYTE_CNT_W'(DATA_BYTES) : {1'b0, enc};
    endfunction

endpackage

// File: design/queue_cfg_pkg.sv
/* Queue memory configuration
   Word, page, queue and port sizes with the widths derived from them */

package queue_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data word
    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = DATA_BYTES * 8;
    // Zero encodes a full word
    localparam int KEEP_ENC_W = 2;
    localparam int BYTE_CNT_W = KEEP_ENC_W + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Paging
    localparam int WORDS_PER_PAGE = 4;
    localparam int OFFSET_W       = 2;
    localparam int NUM_PAGES      = 16;
    localparam int PAGE_W         = 4;
    // Memory word address is {page, offset}
    localparam int ADDR_W         = PAGE_W + OFFSET_W;
    localparam int MEM_DEPTH      = NUM_PAGES * WORDS_PER_PAGE;

    ////////////////////////////////////////////////////////////////////////////
    // Queues and egress ports
    localparam int NUM_QUEUES      = 8;
    localparam int QUEUE_W         = 3;
    localparam int QUEUES_PER_PORT = 2;
    localparam int PORT_W          = 2;

endpackage
